/* logic/uproc_defines.svh */
// Shared sizes and codes; UPROC_BSCAN_LEN must equal the bit width of uproc_pkg::pin_bus_t.
`ifndef UPROC_DEFINES_SVH
`define UPROC_DEFINES_SVH

// ----------------------------------------------------------
// Memory bus and JTAG command framing.
`define UPROC_WORD_W      16
`define UPROC_CMD_W       24

// ----------------------------------------------------------
// Boot copy from SPI storage, always starting at storage address 0.
`define UPROC_BOOT_WORDS  4
`define UPROC_BOOT_BASE   16'h0100
`define UPROC_SPI_READ    8'h03

// Address, data, write, enable, booted and paused.
`define UPROC_BSCAN_LEN   36

// ----------------------------------------------------------
// JTAG opcodes, top 4 bits of a command frame.
`define UPROC_OP_NOP        4'd0
`define UPROC_OP_PAUSE      4'd1
`define UPROC_OP_RUN        4'd2
`define UPROC_OP_SET_ADDR   4'd3
`define UPROC_OP_WRITE      4'd4
`define UPROC_OP_SCAN_ON    4'd5
`define UPROC_OP_SCAN_OFF   4'd6
`define UPROC_OP_SCAN_SHIFT 4'd7

`endif

/* logic/uproc_pkg.sv */
// Field order of pin_bus_t fixes the boundary scan order; bit 0 sits next to TDI.
`default_nettype none

`include "uproc_defines.svh"

package uproc_pkg;

    // ----------------------------------------------------------
    // One memory bus request, 34 bits.
    typedef struct packed {
        logic [`UPROC_WORD_W-1:0] addr;
        logic [`UPROC_WORD_W-1:0] data;
        logic                     wr;
        logic                     en;
    } mem_req_t;

    // Raw or synchronized JTAG input pins.
    typedef struct packed {
        logic tck;
        logic tdi;
        logic tms;
    } jtag_pins_t;

    // Scan strobes are one-cycle pulses; drive is a level.
    typedef struct packed {
        logic capture;
        logic shift;
        logic update;
        logic drive;
    } bscan_ctrl_t;

    // Pin vector in chain order, paused is bit 0.
    typedef struct packed {
        mem_req_t mem;
        logic     booted;
        logic     paused;
    } pin_bus_t;

    // ----------------------------------------------------------
    // Boot sequencer states.
    typedef enum logic [1:0] {
        BOOT_IDLE,
        BOOT_CMD,
        BOOT_DATA,
        BOOT_DONE
    } boot_state_e;

endpackage

`default_nettype wire

/* logic/input_synch.sv */
// TCK must stay at each level for at least three i_clk cycles or edges are lost.
`timescale 1ns/1ps
`default_nettype none

module input_synch (
    input  wire logic                   i_clk,
    input  wire logic                   i_arst_n,
    input  wire uproc_pkg::jtag_pins_t  i_pins,
    output logic                        o_rst_n,
    output uproc_pkg::jtag_pins_t       o_pins,
    output logic                        o_tck_rise
);

    logic [1:0]            rst_q;
    uproc_pkg::jtag_pins_t pins_q1;
    uproc_pkg::jtag_pins_t pins_q2;
    uproc_pkg::jtag_pins_t pins_q3;
    logic                  tck_rise_q;

    // ----------------------------------------------------------
    // Reset asserts at once and releases two edges later.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rst_q <= 2'b00;
        end else begin
            rst_q <= {rst_q[0], 1'b1};
        end
    end

    assign o_rst_n = rst_q[1];

    // ----------------------------------------------------------
    // Two-flop synchronizer.
    // Third stage keeps the previous TCK and aligns TDI/TMS to the pulse.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pins_q1    <= '0;
            pins_q2    <= '0;
            pins_q3    <= '0;
            tck_rise_q <= 1'b0;
        end else begin
            pins_q1    <= i_pins;
            pins_q2    <= pins_q1;
            pins_q3    <= pins_q2;
            tck_rise_q <= pins_q2.tck & ~pins_q3.tck;
        end
    end

    assign o_pins     = pins_q3;
    assign o_tck_rise = tck_rise_q;

endmodule

`default_nettype wire

/* logic/jtag_port.sv */
// Simplified serial command port, not an IEEE 1149.1 TAP; TMS high marks frame bits.
`timescale 1ns/1ps
`default_nettype none

`include "uproc_defines.svh"

module jtag_port (
    input  wire logic                   i_clk,
    input  wire logic                   i_arst_n,
    input  wire uproc_pkg::jtag_pins_t  i_pins,
    input  wire logic                   i_tck_rise,
    input  wire logic                   i_is_booted,
    input  wire logic                   i_core_idle,
    input  wire logic                   i_chain_tail,
    output logic                        o_tdo,
    output uproc_pkg::mem_req_t         o_mem_req,
    output uproc_pkg::bscan_ctrl_t      o_scan,
    output logic                        o_now_paused
);

    localparam int CMD_W = `UPROC_CMD_W;

    logic [CMD_W-1:0]         cmd_q;
    logic                     tms_prev_q;
    logic                     exec_q;
    logic                     pause_req_q;
    logic                     scan_mode_q;
    logic [`UPROC_WORD_W-1:0] addr_q;
    uproc_pkg::mem_req_t      req_q;
    uproc_pkg::bscan_ctrl_t   scan_q;
    logic [3:0]               opcode;
    logic [`UPROC_WORD_W-1:0] arg;
    logic                     shift_edge;
    logic                     frame_end;

    // ----------------------------------------------------------
    // Frame decode.
    assign opcode     = cmd_q[CMD_W-1 -: 4];
    assign arg        = cmd_q[`UPROC_WORD_W-1:0];
    assign shift_edge = i_tck_rise & i_pins.tms;
    // First TMS-low edge after a TMS-high one closes the frame.
    assign frame_end  = i_tck_rise & ~i_pins.tms & tms_prev_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cmd_q       <= '0;
            tms_prev_q  <= 1'b0;
            exec_q      <= 1'b0;
            pause_req_q <= 1'b0;
            scan_mode_q <= 1'b0;
            addr_q      <= '0;
            req_q       <= '0;
            scan_q      <= '0;
        end else begin
            // Strobes are single-cycle by default.
            req_q.wr       <= 1'b0;
            req_q.en       <= 1'b0;
            scan_q.capture <= 1'b0;
            scan_q.shift   <= 1'b0;
            scan_q.update  <= 1'b0;
            exec_q         <= frame_end & ~scan_mode_q;

            if (i_tck_rise) begin
                tms_prev_q <= i_pins.tms;
            end

            // Command bits enter at the top, old bit 0 leaves on TDO.
            if (shift_edge && !scan_mode_q) begin
                cmd_q <= {i_pins.tdi, cmd_q[CMD_W-1:1]};
            end

            // Scan mode steers frame bits into the chain instead.
            if (scan_mode_q) begin
                scan_q.shift <= shift_edge;
                if (frame_end) begin
                    scan_q.update <= 1'b1;
                    scan_mode_q   <= 1'b0;
                end
            end

            // ----------------------------------------------------------
            // Execute one cycle after the frame end.
            if (exec_q) begin
                case (opcode)
                    `UPROC_OP_NOP:      ;
                    `UPROC_OP_PAUSE:    pause_req_q <= 1'b1;
                    `UPROC_OP_RUN:      pause_req_q <= 1'b0;
                    `UPROC_OP_SET_ADDR: addr_q <= arg;
                    `UPROC_OP_WRITE: begin
                        // Dropped unless the bus belongs to this port.
                        if (i_is_booted && o_now_paused) begin
                            req_q  <= '{addr: addr_q, data: arg, wr: 1'b1, en: 1'b1};
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                    `UPROC_OP_SCAN_ON:  scan_q.drive <= 1'b1;
                    `UPROC_OP_SCAN_OFF: scan_q.drive <= 1'b0;
                    `UPROC_OP_SCAN_SHIFT: begin
                        scan_q.capture <= 1'b1;
                        scan_mode_q    <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // ----------------------------------------------------------
    // Outputs.
    // Paused only once the core has also gone idle.
    assign o_now_paused = pause_req_q & i_core_idle;
    assign o_tdo        = scan_mode_q ? i_chain_tail : cmd_q[0];
    assign o_mem_req    = req_q;
    assign o_scan       = scan_q;

endmodule

`default_nettype wire

/* logic/boot_block.sv */
// Runs once per reset; the storage must drive SDO on falling SCK at i_clk/2 rate.
`timescale 1ns/1ps
`default_nettype none

`include "uproc_defines.svh"

module boot_block (
    input  wire logic           i_clk,
    input  wire logic           i_arst_n,
    output logic                o_spi_sck,
    output logic                o_spi_cs_n,
    output logic                o_spi_sdi,
    input  wire logic           i_spi_sdo,
    output uproc_pkg::mem_req_t o_mem_req,
    output logic                o_now_booted
);

    // Read opcode plus a 16-bit storage address.
    localparam int TX_W   = 8 + `UPROC_WORD_W;
    localparam int WCNT_W = $clog2(`UPROC_BOOT_WORDS + 1);

    uproc_pkg::boot_state_e   state_q;
    logic [4:0]               bit_cnt_q;
    logic [WCNT_W-1:0]        word_cnt_q;
    logic [TX_W-1:0]          tx_q;
    logic [`UPROC_WORD_W-1:0] rx_q;
    logic                     sck_q;
    logic                     cs_n_q;
    logic                     booted_q;
    uproc_pkg::mem_req_t      req_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q    <= uproc_pkg::BOOT_IDLE;
            bit_cnt_q  <= '0;
            word_cnt_q <= '0;
            tx_q       <= '0;
            rx_q       <= '0;
            sck_q      <= 1'b0;
            cs_n_q     <= 1'b1;
            booted_q   <= 1'b0;
            req_q      <= '0;
        end else begin
            req_q.wr <= 1'b0;
            req_q.en <= 1'b0;

            case (state_q)
                // ----------------------------------------------------------
                // Select the device and load the read command.
                uproc_pkg::BOOT_IDLE: begin
                    cs_n_q  <= 1'b0;
                    tx_q    <= {`UPROC_SPI_READ, {`UPROC_WORD_W{1'b0}}};
                    state_q <= uproc_pkg::BOOT_CMD;
                end

                // Command phase.
                // SDI moves on the clock that drops SCK.
                uproc_pkg::BOOT_CMD: begin
                    sck_q <= ~sck_q;
                    if (sck_q) begin
                        tx_q      <= tx_q << 1;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 5'(TX_W - 1)) begin
                            bit_cnt_q <= '0;
                            state_q   <= uproc_pkg::BOOT_DATA;
                        end
                    end
                end

                // ----------------------------------------------------------
                // Data phase.
                // SDO is sampled on the clock that raises SCK.
                uproc_pkg::BOOT_DATA: begin
                    sck_q <= ~sck_q;
                    if (!sck_q) begin
                        rx_q      <= {rx_q[`UPROC_WORD_W-2:0], i_spi_sdo};
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 5'(`UPROC_WORD_W - 1)) begin
                            // Word complete, emit one write.
                            bit_cnt_q  <= '0;
                            word_cnt_q <= word_cnt_q + 1'b1;
                            req_q.addr <= `UPROC_BOOT_BASE + `UPROC_WORD_W'(word_cnt_q);
                            req_q.data <= {rx_q[`UPROC_WORD_W-2:0], i_spi_sdo};
                            req_q.wr   <= 1'b1;
                            req_q.en   <= 1'b1;
                            if (word_cnt_q == WCNT_W'(`UPROC_BOOT_WORDS - 1)) begin
                                cs_n_q  <= 1'b1;
                                state_q <= uproc_pkg::BOOT_DONE;
                            end
                        end
                    end
                end

                // Booted rises a cycle after the last write.
                // The controller still routes that write from boot.
                uproc_pkg::BOOT_DONE: begin
                    sck_q    <= 1'b0;
                    booted_q <= 1'b1;
                end

                default: state_q <= uproc_pkg::BOOT_IDLE;
            endcase
        end
    end

    assign o_spi_sck    = sck_q;
    assign o_spi_cs_n   = cs_n_q;
    assign o_spi_sdi    = tx_q[TX_W-1];
    assign o_mem_req    = req_q;
    assign o_now_booted = booted_q;

endmodule

`default_nettype wire

/* logic/mem_controller.sv */
// Requests are fire-and-forget; a request from a source not currently selected is lost.
`timescale 1ns/1ps
`default_nettype none

module mem_controller (
    input  wire logic                i_clk,
    input  wire logic                i_arst_n,
    input  wire uproc_pkg::mem_req_t i_boot_req,
    input  wire uproc_pkg::mem_req_t i_jtag_req,
    input  wire uproc_pkg::mem_req_t i_core_req,
    input  wire logic                i_is_booted,
    input  wire logic                i_is_paused,
    output uproc_pkg::mem_req_t      o_mem
);

    uproc_pkg::mem_req_t sel_req;
    uproc_pkg::mem_req_t mem_q;

    // ----------------------------------------------------------
    // Source rule.
    // Boot owns the bus until booted, then JTAG while paused.
    always_comb begin
        if (!i_is_booted) begin
            sel_req = i_boot_req;
        end else if (i_is_paused) begin
            sel_req = i_jtag_req;
        end else begin
            sel_req = i_core_req;
        end
    end

    // Bus changes only on clock edges.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mem_q <= '0;
        end else begin
            mem_q <= sel_req;
        end
    end

    assign o_mem = mem_q;

endmodule

`default_nettype wire

/* logic/bscan_cell.sv */
// Runs on i_clk with one-cycle strobes from the JTAG port, never on TCK itself.
`timescale 1ns/1ps
`default_nettype none

module bscan_cell (
    input  wire logic                   i_clk,
    input  wire logic                   i_arst_n,
    input  wire logic                   i_func,
    input  wire logic                   i_shift_in,
    input  wire uproc_pkg::bscan_ctrl_t i_scan,
    output logic                        o_pin,
    output logic                        o_shift_out
);

    logic shift_q;
    logic update_q;

    // ----------------------------------------------------------
    // Capture wins over shift.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            shift_q  <= 1'b0;
            update_q <= 1'b0;
        end else begin
            if (i_scan.capture) begin
                shift_q <= i_func;
            end else if (i_scan.shift) begin
                shift_q <= i_shift_in;
            end
            if (i_scan.update) begin
                update_q <= shift_q;
            end
        end
    end

    // Pin follows the function unless scan drives it.
    assign o_pin       = i_scan.drive ? update_q : i_func;
    assign o_shift_out = shift_q;

endmodule

`default_nettype wire

/* logic/uproc_top.sv */
// No processor core inside; core requests and idle come from outside and pins are outputs only.
`timescale 1ns/1ps
`default_nettype none

`include "uproc_defines.svh"

module uproc_top (
    input  wire logic                   i_clk,
    input  wire logic                   i_arst_n,
    input  wire uproc_pkg::jtag_pins_t  i_jtag,
    output logic                        o_jtag_tdo,
    output logic                        o_spi_sck,
    output logic                        o_spi_cs_n,
    output logic                        o_spi_sdi,
    input  wire logic                   i_spi_sdo,
    input  wire uproc_pkg::mem_req_t    i_core_req,
    input  wire logic                   i_core_idle,
    output uproc_pkg::pin_bus_t         o_pins
);

    localparam int LEN = `UPROC_BSCAN_LEN;

    logic                   rst_n;
    uproc_pkg::jtag_pins_t  jtag_sync;
    logic                   tck_rise;
    uproc_pkg::mem_req_t    boot_req;
    uproc_pkg::mem_req_t    jtag_req;
    uproc_pkg::mem_req_t    mem_bus;
    uproc_pkg::bscan_ctrl_t scan_ctrl;
    logic                   now_booted;
    logic                   now_paused;
    uproc_pkg::pin_bus_t    func_pins;
    logic [LEN-1:0]         pin_vec;
    // Chain link i feeds cell i; link 0 is TDI, link LEN the tail.
    logic [LEN:0]           chain;

    // ----------------------------------------------------------
    // Reset and JTAG pin synchronization.
    input_synch u_input_synch (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_pins     (i_jtag),
        .o_rst_n    (rst_n),
        .o_pins     (jtag_sync),
        .o_tck_rise (tck_rise)
    );

    // Command port, also drains the scan chain.
    jtag_port u_jtag_port (
        .i_clk        (i_clk),
        .i_arst_n     (rst_n),
        .i_pins       (jtag_sync),
        .i_tck_rise   (tck_rise),
        .i_is_booted  (now_booted),
        .i_core_idle  (i_core_idle),
        .i_chain_tail (chain[LEN]),
        .o_tdo        (o_jtag_tdo),
        .o_mem_req    (jtag_req),
        .o_scan       (scan_ctrl),
        .o_now_paused (now_paused)
    );

    // ----------------------------------------------------------
    // Boot copy from SPI storage.
    boot_block u_boot_block (
        .i_clk        (i_clk),
        .i_arst_n     (rst_n),
        .o_spi_sck    (o_spi_sck),
        .o_spi_cs_n   (o_spi_cs_n),
        .o_spi_sdi    (o_spi_sdi),
        .i_spi_sdo    (i_spi_sdo),
        .o_mem_req    (boot_req),
        .o_now_booted (now_booted)
    );

    // Bus owner select.
    mem_controller u_mem_controller (
        .i_clk       (i_clk),
        .i_arst_n    (rst_n),
        .i_boot_req  (boot_req),
        .i_jtag_req  (jtag_req),
        .i_core_req  (i_core_req),
        .i_is_booted (now_booted),
        .i_is_paused (now_paused),
        .o_mem       (mem_bus)
    );

    // ----------------------------------------------------------
    // Boundary scan chain, zero-latency path to the pins.
    assign func_pins = '{mem: mem_bus, booted: now_booted, paused: now_paused};
    assign chain[0]  = jtag_sync.tdi;

    for (genvar i = 0; i < LEN; i++) begin : g_bscan
        bscan_cell u_cell (
            .i_clk       (i_clk),
            .i_arst_n    (rst_n),
            .i_func      (func_pins[i]),
            .i_shift_in  (chain[i]),
            .i_scan      (scan_ctrl),
            .o_pin       (pin_vec[i]),
            .o_shift_out (chain[i+1])
        );
    end

    assign o_pins = uproc_pkg::pin_bus_t'(pin_vec);

endmodule

`default_nettype wire

/* test/uproc_tb_assert.sv */
// Protocol checks bound into uproc_top; they look at internal nets, so net names there must hold.
`timescale 1ns/1ps
`default_nettype none

module uproc_tb_assert (
    input wire logic                   i_clk,
    input wire logic                   i_arst_n,
    input wire uproc_pkg::mem_req_t    i_jtag_req,
    input wire logic                   i_paused,
    input wire logic                   i_booted,
    input wire uproc_pkg::bscan_ctrl_t i_scan
);

    // Number of failed properties so far.
    int fail_cnt = 0;

    // ----------------------------------------------------------
    // A JTAG write only leaves the port while the MCU is paused.
    a_jtag_write_paused : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_jtag_req.en |-> i_paused)
        else begin
            fail_cnt++;
            $error("JTAG write request issued while the MCU is not paused");
        end

    // Booted is sticky until reset.
    a_booted_sticky : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !$fell(i_booted))
        else begin
            fail_cnt++;
            $error("Booted flag fell without a reset");
        end

    // At most one scan strobe per cycle.
    a_scan_strobes : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({i_scan.capture, i_scan.shift, i_scan.update}))
        else begin
            fail_cnt++;
            $error("Capture, shift and update strobes overlap");
        end

endmodule

bind uproc_top uproc_tb_assert u_assert (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_jtag_req (jtag_req),
    .i_paused   (now_paused),
    .i_booted   (now_booted),
    .i_scan     (scan_ctrl)
);

`default_nettype wire

/* test/uproc_tb.sv */
// Storage model serves only the first boot after reset; TCK levels last 8 clocks each.
`timescale 1ns/1ps
`default_nettype none

`include "uproc_defines.svh"

module uproc_tb;

    localparam int CMD_W     = `UPROC_CMD_W;
    localparam int LEN       = `UPROC_BSCAN_LEN;
    localparam int TCK_HOLD  = 8;
    localparam int NUM_STEPS = 8;
    // Eleven 25-bit command frames and one 37-bit scan frame at 16 clocks a bit, plus boot.
    // That comes to about 5400 cycles.
    localparam int MAX_CYCLES = 20000;

    // One row of the command table.
    typedef struct packed {
        logic [3:0]               op;
        logic [`UPROC_WORD_W-1:0] arg;
        logic                     idle;
        logic                     exp_paused;
        logic                     exp_core;
        logic                     exp_wr;
        logic [`UPROC_WORD_W-1:0] exp_addr;
    } step_t;

    logic                  i_clk;
    logic                  i_arst_n;
    uproc_pkg::jtag_pins_t i_jtag;
    logic                  o_jtag_tdo;
    logic                  o_spi_sck;
    logic                  o_spi_cs_n;
    logic                  o_spi_sdi;
    logic                  i_spi_sdo;
    uproc_pkg::mem_req_t   i_core_req;
    logic                  i_core_idle;
    uproc_pkg::pin_bus_t   o_pins;

    logic [`UPROC_WORD_W-1:0] boot_words [`UPROC_BOOT_WORDS];
    step_t                    steps [NUM_STEPS];
    uproc_pkg::mem_req_t      exp_q [$];
    uproc_pkg::mem_req_t      seen_w;
    logic [CMD_W-1:0]         prev_cmd  = '0;
    logic                     bus_watch = 1'b1;
    int                       cycle_cnt = 0;

    // SPI storage model state.
    logic        sck_prev = 1'b0;
    logic [23:0] spi_cmd  = '0;
    int          cmd_bits = 0;
    int          bits_out = 0;

    uproc_top uut (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_jtag      (i_jtag),
        .o_jtag_tdo  (o_jtag_tdo),
        .o_spi_sck   (o_spi_sck),
        .o_spi_cs_n  (o_spi_cs_n),
        .o_spi_sdi   (o_spi_sdi),
        .i_spi_sdo   (i_spi_sdo),
        .i_core_req  (i_core_req),
        .i_core_idle (i_core_idle),
        .o_pins      (o_pins)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // ----------------------------------------------------------
    // Helpers.
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // Random core read; reads never show up as writes on the bus.
    function automatic uproc_pkg::mem_req_t rand_read();
        uproc_pkg::mem_req_t rq;
        rq.addr = `UPROC_WORD_W'($urandom());
        rq.data = `UPROC_WORD_W'($urandom());
        rq.wr   = 1'b0;
        rq.en   = 1'b1;
        return rq;
    endfunction

    // One TCK period; TDO is sampled just before the rising edge.
    task automatic jtag_bit(input logic tdi, input logic tms, output logic tdo);
        @(negedge i_clk);
        i_jtag <= '{tck: 1'b0, tdi: tdi, tms: tms};
        repeat (TCK_HOLD) @(negedge i_clk);
        tdo = o_jtag_tdo;
        i_jtag.tck <= 1'b1;
        repeat (TCK_HOLD - 1) @(negedge i_clk);
    endtask

    task automatic jtag_rest();
        @(negedge i_clk);
        i_jtag.tck <= 1'b0;
        repeat (TCK_HOLD) @(negedge i_clk);
    endtask

    // Command goes out LSB first; old command must come back on TDO.
    task automatic send_cmd(input logic [3:0] op, input logic [`UPROC_WORD_W-1:0] arg);
        logic [CMD_W-1:0] cmd;
        logic             tdo;
        int               i;
        cmd = {op, 4'h0, arg};
        for (i = 0; i < CMD_W; i++) begin
            jtag_bit(cmd[i], 1'b1, tdo);
            assert (tdo === prev_cmd[i])
                else stop_on_error($sformatf("** Error: o_jtag_tdo bit %0d got %h expected %h",
                                             i, tdo, prev_cmd[i]));
        end
        // TMS low closes the frame.
        jtag_bit(1'b0, 1'b0, tdo);
        prev_cmd = cmd;
        jtag_rest();
    endtask

    // Scan frame; the first bit sent ends up in the cell next to TDO.
    task automatic scan_frame(input uproc_pkg::pin_bus_t pat, input uproc_pkg::pin_bus_t cap);
        logic tdo;
        int   k;
        for (k = LEN - 1; k >= 0; k--) begin
            jtag_bit(pat[k], 1'b1, tdo);
            assert (tdo === cap[k])
                else stop_on_error($sformatf("** Error: o_jtag_tdo scan bit %0d got %h expected %h",
                                             k, tdo, cap[k]));
        end
        jtag_bit(1'b0, 1'b0, tdo);
        jtag_rest();
    endtask

    // Core read appears on the bus one cycle later, or the bus stays idle.
    task automatic check_core_path(input logic exp_pass);
        uproc_pkg::mem_req_t rq;
        rq = rand_read();
        @(negedge i_clk);
        i_core_req <= rq;
        @(negedge i_clk);
        if (exp_pass) begin
            assert (o_pins.mem == rq)
                else stop_on_error($sformatf("** Error: o_pins.mem got %h expected %h",
                                             o_pins.mem, rq));
        end else begin
            assert (o_pins.mem.en == 1'b0)
                else stop_on_error($sformatf("** Error: o_pins.mem.en got %h expected %h",
                                             o_pins.mem.en, 1'b0));
        end
        i_core_req <= '0;
    endtask

    // ----------------------------------------------------------
    // SPI storage. Reads the command on rising SCK, answers on falling SCK.
    always @(negedge i_clk) begin
        if (!o_spi_cs_n) begin
            if (o_spi_sck && !sck_prev && cmd_bits < 24) begin
                spi_cmd  = {spi_cmd[22:0], o_spi_sdi};
                cmd_bits = cmd_bits + 1;
                if (cmd_bits == 24) begin
                    assert (spi_cmd == {`UPROC_SPI_READ, 16'h0000})
                        else stop_on_error($sformatf("** Error: o_spi_sdi command got %h expected %h",
                                                     spi_cmd, {`UPROC_SPI_READ, 16'h0000}));
                end
            end else if (!o_spi_sck && sck_prev && cmd_bits == 24
                         && bits_out < 16 * `UPROC_BOOT_WORDS) begin
                i_spi_sdo <= boot_words[bits_out / 16][15 - (bits_out % 16)];
                bits_out = bits_out + 1;
            end
        end
        sck_prev = o_spi_sck;
    end

    // Bus monitor. Every write must match the next expected one.
    always @(negedge i_clk) begin
        if (bus_watch && o_pins.mem.en && o_pins.mem.wr) begin
            assert (exp_q.size() > 0)
                else stop_on_error($sformatf("Unexpected memory write to %h on o_pins.",
                                             o_pins.mem.addr));
            seen_w = exp_q.pop_front();
            assert (o_pins.mem == seen_w)
                else stop_on_error($sformatf("** Error: o_pins.mem got %h expected %h",
                                             o_pins.mem, seen_w));
        end
    end

    // Protocol properties bound into the DUT.
    always @(negedge i_clk) begin
        assert (uut.u_assert.fail_cnt == 0)
            else stop_on_error("A bound protocol assertion in uproc_top failed.");
    end

    // Watchdog.
    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
        $display("TESTS FAILED");
        $fatal(1);
    end

    // ----------------------------------------------------------
    // Main sequence.
    initial begin : main
        uproc_pkg::pin_bus_t func_exp;
        uproc_pkg::pin_bus_t scan_pat;
        uproc_pkg::mem_req_t core_hold;
        logic [63:0]         rnd;
        int                  s;

        void'($urandom(32'hcfca));
        i_arst_n    = 1'b0;
        i_jtag      = '0;
        i_spi_sdo   = 1'b0;
        i_core_req  = '0;
        i_core_idle = 1'b0;

        boot_words = '{16'hc0de, 16'h1f2e, 16'h8001, 16'h7ffe};
        // op, arg, idle, paused, core passes, write, write address.
        steps[0] = '{`UPROC_OP_PAUSE,    16'h0000, 1'b0, 1'b0, 1'b1, 1'b0, 16'h0000};
        steps[1] = '{`UPROC_OP_NOP,      16'h0000, 1'b1, 1'b1, 1'b0, 1'b0, 16'h0000};
        steps[2] = '{`UPROC_OP_SET_ADDR, 16'h0200, 1'b1, 1'b1, 1'b0, 1'b0, 16'h0000};
        steps[3] = '{`UPROC_OP_WRITE,    16'ha5a5, 1'b1, 1'b1, 1'b0, 1'b1, 16'h0200};
        steps[4] = '{`UPROC_OP_WRITE,    16'h5a5a, 1'b1, 1'b1, 1'b0, 1'b1, 16'h0201};
        steps[5] = '{`UPROC_OP_WRITE,    16'h1234, 1'b1, 1'b1, 1'b0, 1'b1, 16'h0202};
        steps[6] = '{`UPROC_OP_RUN,      16'h0000, 1'b1, 1'b0, 1'b1, 1'b0, 16'h0000};
        steps[7] = '{`UPROC_OP_WRITE,    16'hdead, 1'b1, 1'b0, 1'b1, 1'b0, 16'h0000};

        for (s = 0; s < `UPROC_BOOT_WORDS; s++) begin
            exp_q.push_back('{addr: `UPROC_BOOT_BASE + 16'(s), data: boot_words[s],
                              wr: 1'b1, en: 1'b1});
        end

        // Everything quiet while reset is held.
        repeat (5) @(negedge i_clk);
        assert (o_pins.mem.en == 1'b0 && o_pins.booted == 1'b0 && o_pins.paused == 1'b0)
            else stop_on_error($sformatf("** Error: o_pins in reset got %h expected %h",
                                         o_pins, {LEN{1'b0}}));
        assert (o_spi_cs_n == 1'b1)
            else stop_on_error($sformatf("** Error: o_spi_cs_n got %h expected %h",
                                         o_spi_cs_n, 1'b1));
        i_arst_n <= 1'b1;

        // Boot copy, then the core owns the bus.
        while (!o_pins.booted) @(negedge i_clk);
        repeat (2) @(negedge i_clk);
        assert (exp_q.size() == 0)
            else stop_on_error($sformatf("Boot left %0d expected writes unseen.", exp_q.size()));
        assert (o_spi_cs_n == 1'b1)
            else stop_on_error($sformatf("** Error: o_spi_cs_n got %h expected %h",
                                         o_spi_cs_n, 1'b1));
        repeat (3) check_core_path(1'b1);

        // ----------------------------------------------------------
        // Command table.
        for (s = 0; s < NUM_STEPS; s++) begin
            @(negedge i_clk);
            i_core_idle <= steps[s].idle;
            if (steps[s].exp_wr) begin
                exp_q.push_back('{addr: steps[s].exp_addr, data: steps[s].arg,
                                  wr: 1'b1, en: 1'b1});
            end
            send_cmd(steps[s].op, steps[s].arg);
            assert (o_pins.paused == steps[s].exp_paused)
                else stop_on_error($sformatf("** Error: o_pins.paused step %0d got %h expected %h",
                                             s, o_pins.paused, steps[s].exp_paused));
            check_core_path(steps[s].exp_core);
        end
        assert (exp_q.size() == 0)
            else stop_on_error($sformatf("JTAG writes missing, %0d still expected.", exp_q.size()));

        // ----------------------------------------------------------
        // Boundary scan with a steady core read on the bus.
        core_hold = rand_read();
        @(negedge i_clk);
        i_core_idle <= 1'b0;
        i_core_req  <= core_hold;
        repeat (2) @(negedge i_clk);
        func_exp = '{mem: core_hold, booted: 1'b1, paused: 1'b0};
        assert (o_pins == func_exp)
            else stop_on_error($sformatf("** Error: o_pins got %h expected %h", o_pins, func_exp));

        send_cmd(`UPROC_OP_SCAN_SHIFT, 16'h0000);
        rnd      = {$urandom(), $urandom()};
        scan_pat = rnd[LEN-1:0];
        scan_frame(scan_pat, func_exp);

        // Driven pins may look like writes.
        bus_watch = 1'b0;
        send_cmd(`UPROC_OP_SCAN_ON, 16'h0000);
        assert (o_pins == scan_pat)
            else stop_on_error($sformatf("** Error: o_pins got %h expected %h", o_pins, scan_pat));
        send_cmd(`UPROC_OP_SCAN_OFF, 16'h0000);
        assert (o_pins == func_exp)
            else stop_on_error($sformatf("** Error: o_pins got %h expected %h", o_pins, func_exp));
        bus_watch = 1'b1;

        repeat (4) @(negedge i_clk);
        if (uut.u_assert.fail_cnt == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/uproc_pkg.sv
logic/input_synch.sv
logic/jtag_port.sv
logic/boot_block.sv
logic/mem_controller.sv
logic/bscan_cell.sv
logic/uproc_top.sv
test/uproc_tb_assert.sv
test/uproc_tb.sv

/* Bender.yml */
package:
  name: uproc_debug_boot

export_include_dirs:
  - logic

sources:
  - files:
      - logic/uproc_pkg.sv
      - logic/input_synch.sv
      - logic/jtag_port.sv
      - logic/boot_block.sv
      - logic/mem_controller.sv
      - logic/bscan_cell.sv
      - logic/uproc_top.sv
  - target: test
    files:
      - test/uproc_tb_assert.sv
      - test/uproc_tb.sv
